//--- sources.f
common/PathBufferPkg.sv
pathPortArbiter/PathBlockCounter.sv
pathPortArbiter/PathPortArbiter.sv
verilog/PathBufferRam.sv
verilog/EncryptOutQueue.sv
verilog/PathBufferPort.sv
testbench/PathBufferPortTb.sv

//--- Bender.yml
package:
  name: path_buffer_port

sources:
  - common/PathBufferPkg.sv
  - pathPortArbiter/PathBlockCounter.sv
  - pathPortArbiter/PathPortArbiter.sv
  - verilog/PathBufferRam.sv
  - verilog/EncryptOutQueue.sv
  - verilog/PathBufferPort.sv
  - target: test
    files:
      - testbench/PathBufferPortTb.sv

//--- testbench/PathBufferPortTb.sv
// PathBufferPortTb
// Random read-write path traffic on the path buffer port, checked against a
// model of the buffer, the block counter and the encryption queue

`timescale 1ns/10ps
`default_nettype none

module PathBufferPortTb import PathBufferPkg::*;;

	localparam int DataWidth = 32;
	localparam int PathBursts = 6;
	localparam int CountWidth = BlockCountWidth(PathBursts);
	localparam int NumAccesses = 20;
	localparam int AccessCycles = 80; // Read, idle, read-back, fill and drain of one access
	localparam int TimeoutCycles = 4 * (NumAccesses * AccessCycles + 2 + 10);

	logic Clock = 1'b0;
	logic rst, RWAccess, CSPathRead, CSPathWriteback, DecTransfer, StashTransfer;
	logic StashReadEnable, EncTake, EncValid, PathTransition;
	logic [DataWidth-1:0] DecData, StashData, StashReadData, EncData;
	logic [CountWidth-1:0] StashReadAddr, BlockCount;

	logic [DataWidth-1:0] modelBuf [0:2*PathBursts+1]; // Two halves plus spares
	logic [DataWidth-1:0] modelQueue[$]; // Blocks held in the encryption queue
	logic [DataWidth-1:0] expectEnc[$]; // Stash words still to come out, in order
	logic [DataWidth-1:0] pendingData, stashExpect;
	logic modelFill, pushPending, stashPending;
	int modelCount, cycles = 0;
	int wordErrors = 0, countErrors = 0, flagErrors = 0, otherErrors = 0;

	PathBufferPort #(.DataWidth(DataWidth), .PathBursts(PathBursts)) PathBufferPort_inst (
		.Clock(Clock), .rst(rst), .RWAccess(RWAccess), .CSPathRead(CSPathRead),
		.CSPathWriteback(CSPathWriteback), .DecTransfer(DecTransfer), .DecData(DecData),
		.StashTransfer(StashTransfer), .StashData(StashData),
		.StashReadEnable(StashReadEnable), .StashReadAddr(StashReadAddr),
		.StashReadData(StashReadData), .EncTake(EncTake), .EncData(EncData),
		.EncValid(EncValid), .PathTransition(PathTransition), .BlockCount(BlockCount)
	);

	always #20 Clock = ~Clock; // 40 ns period

	always @(posedge Clock) cycles <= cycles + 1;

	task automatic checkWord(input string name, input logic [DataWidth-1:0] got,
			input logic [DataWidth-1:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, expected);
			wordErrors++;
		end
	endtask

	task automatic checkCount(input string name, input logic [CountWidth-1:0] got,
			input logic [CountWidth-1:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, expected);
			countErrors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, expected);
			flagErrors++;
		end
	endtask

	// Model steps at the falling edge, where inputs and outputs are settled
	always @(negedge Clock) begin : modelStep
		logic expEnable;
		logic expWrite;
		int addr;
		if (rst) begin
			modelFill = 1'b1;
			modelCount = 0;
			pushPending = 1'b0;
			stashPending = 1'b0;
			modelQueue.delete();
		end else begin
			if (stashPending) checkWord("StashReadData", StashReadData, stashExpect);
			checkFlag("EncValid", EncValid, modelQueue.size() != 0);
			if (modelQueue.size() != 0) checkWord("EncData", EncData, modelQueue[0]);
			expEnable = 1'b0;
			expWrite = 1'b0;
			addr = modelCount;
			if (RWAccess && CSPathRead) begin
				expEnable = DecTransfer;
				expWrite = 1'b1;
			end else if (RWAccess && CSPathWriteback) begin
				addr = modelCount + PathBursts; // Upper half
				expEnable = modelFill ? StashTransfer
					: (QueueDepth - modelQueue.size()) > int'(pushPending);
				expWrite = modelFill;
			end
			checkFlag("PathTransition", PathTransition,
				expEnable && modelCount == PathBursts - 1);
			checkCount("BlockCount", BlockCount, CountWidth'(modelCount));
			stashPending = StashReadEnable;
			stashExpect = modelBuf[StashReadAddr];
			// Every block the DUT hands over must be the next stash word
			if (EncTake && EncValid) begin
				if (expectEnc.size() == 0) begin
					$display("Block taken from the encryption queue with none expected");
					otherErrors++;
				end else begin
					checkWord("EncData", EncData, expectEnc.pop_front());
				end
			end
			if (EncTake && modelQueue.size() != 0) begin
				void'(modelQueue.pop_front());
			end
			if (pushPending) modelQueue.push_back(pendingData);
			pushPending = expEnable && !expWrite; // Drain read lands next cycle
			if (expEnable) begin
				if (expWrite) modelBuf[addr] = CSPathRead ? DecData : StashData;
				else pendingData = modelBuf[addr];
				if (modelCount == PathBursts - 1) begin
					modelCount = 0;
					if (CSPathWriteback) modelFill = !modelFill;
				end else begin
					modelCount++;
				end
			end
		end
	end

	task automatic readPhase();
		int gap;
		@(posedge Clock);
		RWAccess <= 1'b1;
		CSPathRead <= 1'b1;
		for (int i = 0; i < PathBursts; i++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) begin
				@(posedge Clock);
				DecTransfer <= 1'b0;
			end
			@(posedge Clock);
			DecTransfer <= 1'b1;
			DecData <= $urandom();
		end
		@(posedge Clock);
		DecTransfer <= 1'b0;
		CSPathRead <= 1'b0;
		RWAccess <= 1'b0;
	endtask

	// Strobes outside an access must leave buffer and queue alone
	task automatic idleStrobes();
		repeat (5) begin
			@(posedge Clock);
			CSPathRead <= $urandom_range(1, 0);
			CSPathWriteback <= $urandom_range(1, 0);
			DecTransfer <= $urandom_range(1, 0);
			StashTransfer <= $urandom_range(1, 0);
			DecData <= $urandom();
			StashData <= $urandom();
			EncTake <= $urandom_range(1, 0);
		end
		@(posedge Clock);
		{CSPathRead, CSPathWriteback, DecTransfer, StashTransfer, EncTake} <= '0;
	endtask

	task automatic readBack();
		for (int i = 0; i < PathBursts; i++) begin
			@(posedge Clock);
			StashReadEnable <= 1'b1;
			StashReadAddr <= CountWidth'(i);
		end
		@(posedge Clock);
		StashReadEnable <= 1'b0;
	endtask

	task automatic writeback(input logic holdTake);
		int gap;
		logic [DataWidth-1:0] word;
		@(posedge Clock);
		RWAccess <= 1'b1;
		CSPathWriteback <= 1'b1;
		for (int i = 0; i < PathBursts; i++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) begin
				@(posedge Clock);
				StashTransfer <= 1'b0;
				EncTake <= $urandom_range(1, 0);
			end
			@(posedge Clock);
			word = $urandom();
			StashTransfer <= 1'b1;
			StashData <= word;
			expectEnc.push_back(word);
		end
		@(posedge Clock);
		StashTransfer <= 1'b0;
		if (holdTake) begin
			EncTake <= 1'b0;
			repeat (10) @(posedge Clock);
			@(negedge Clock);
			checkFlag("EncValid", EncValid, 1'b1); // Queue full, drain stalled
			checkCount("BlockCount", BlockCount, CountWidth'(QueueDepth));
		end
		do begin
			@(posedge Clock);
			EncTake <= $urandom_range(1, 0);
		end while (!modelFill);
		@(posedge Clock);
		CSPathWriteback <= 1'b0;
		RWAccess <= 1'b0;
		while (expectEnc.size() != 0) begin
			@(posedge Clock);
			EncTake <= $urandom_range(1, 0);
		end
		@(posedge Clock);
		EncTake <= 1'b0;
	endtask

	initial begin
		void'($urandom(17));
		rst <= 1'b1;
		{RWAccess, CSPathRead, CSPathWriteback, DecTransfer, StashTransfer} <= '0;
		{StashReadEnable, EncTake} <= '0;
		DecData <= '0;
		StashData <= '0;
		StashReadAddr <= '0;
		repeat (2) @(posedge Clock);
		rst <= 1'b0;
		@(negedge Clock);
		checkFlag("EncValid", EncValid, 1'b0);
		for (int a = 0; a < NumAccesses; a++) begin
			readPhase();
			idleStrobes();
			readBack();
			writeback(a % 4 == 1); // Every fourth access stalls the queue
		end
		repeat (2) @(posedge Clock);
		$display("Errors: data %0d, count %0d, flag %0d, other %0d",
			wordErrors, countErrors, flagErrors, otherErrors);
		if (wordErrors + countErrors + flagErrors + otherErrors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (cycles >= TimeoutCycles);
		$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/PathBufferPort.sv
// PathBufferPort
// Path buffer port of the ORAM controller, ties arbiter, buffer and queue

`timescale 1ns/10ps
`default_nettype none

module PathBufferPort import PathBufferPkg::*; #(
	parameter int DataWidth = DefaultDataWidth,
	parameter int PathBursts = DefaultPathBursts
) (
	input  wire                                   Clock,
	input  wire                                   rst,
	input  wire                                   RWAccess,
	input  wire                                   CSPathRead,
	input  wire                                   CSPathWriteback,
	input  wire                                   DecTransfer,
	input  wire  [DataWidth-1:0]                  DecData,
	input  wire                                   StashTransfer,
	input  wire  [DataWidth-1:0]                  StashData,
	input  wire                                   StashReadEnable,
	input  wire  [BlockCountWidth(PathBursts)-1:0] StashReadAddr,
	output logic [DataWidth-1:0]                  StashReadData,
	input  wire                                   EncTake,
	output logic [DataWidth-1:0]                  EncData,
	output logic                                  EncValid,
	output logic                                  PathTransition,
	output logic [BlockCountWidth(PathBursts)-1:0] BlockCount
);

	logic portEnable;
	logic portWrite;
	logic [BufferAddrWidth(PathBursts)-1:0] portAddr;
	logic [DataWidth-1:0] portDataIn;
	logic [DataWidth-1:0] portDataOut; // Drain data straight into the queue
	logic queuePush;
	logic [QueueFreeWidth-1:0] queueFree;

	PathPortArbiter #(
		.DataWidth(DataWidth),
		.PathBursts(PathBursts)
	) arbiter (
		.Clock(Clock),
		.rst(rst),
		.RWAccess(RWAccess),
		.CSPathRead(CSPathRead),
		.CSPathWriteback(CSPathWriteback),
		.DecTransfer(DecTransfer),
		.StashTransfer(StashTransfer),
		.DecData(DecData),
		.StashData(StashData),
		.QueueFree(queueFree),
		.PortEnable(portEnable),
		.PortWrite(portWrite),
		.PortAddr(portAddr),
		.PortDataIn(portDataIn),
		.QueuePush(queuePush),
		.PathTransition(PathTransition),
		.BlockCount(BlockCount)
	);

	PathBufferRam #(
		.DataWidth(DataWidth),
		.PathBursts(PathBursts)
	) buffer (
		.Clock(Clock),
		.PortEnable(portEnable),
		.PortWrite(portWrite),
		.PortAddr(portAddr),
		.PortDataIn(portDataIn),
		.StashReadEnable(StashReadEnable),
		.StashReadAddr(StashReadAddr),
		.PortDataOut(portDataOut),
		.StashReadData(StashReadData)
	);

	EncryptOutQueue #(
		.DataWidth(DataWidth)
	) encQueue (
		.Clock(Clock),
		.rst(rst),
		.Push(queuePush),
		.PushData(portDataOut),
		.EncTake(EncTake),
		.EncData(EncData),
		.EncValid(EncValid),
		.QueueFree(queueFree)
	);

endmodule

`default_nettype wire

//--- verilog/EncryptOutQueue.sv
// EncryptOutQueue
// Two-entry queue of drained blocks waiting for the encryption unit

`timescale 1ns/10ps
`default_nettype none

module EncryptOutQueue import PathBufferPkg::*; #(
	parameter int DataWidth = DefaultDataWidth
) (
	input  wire                        Clock,
	input  wire                        rst,
	input  wire                        Push,
	input  wire  [DataWidth-1:0]       PushData,
	input  wire                        EncTake,
	output logic [DataWidth-1:0]       EncData,
	output logic                       EncValid,
	output logic [QueueFreeWidth-1:0]  QueueFree
);

	logic [DataWidth-1:0] tailData; // Second entry, behind the head
	logic [QueueFreeWidth-1:0] used;
	logic take;

	assign EncValid = used != '0;
	assign take = EncTake && EncValid; // Take only counts with a block present
	assign QueueFree = QueueFreeWidth'(QueueDepth) - used;

	always_ff @(posedge Clock) begin
		if (rst) begin
			used <= '0;
		end else if (Push && !take) begin
			used <= used + 1'b1;
		end else if (take && !Push) begin
			used <= used - 1'b1;
		end
	end

	always_ff @(posedge Clock) begin
		if (take) begin
			if (used == QueueFreeWidth'(2)) begin
				EncData <= tailData; // Tail moves up
				if (Push) begin
					tailData <= PushData;
				end
			end else if (Push) begin
				EncData <= PushData;
			end
		end else if (Push) begin
			if (used == '0) begin
				EncData <= PushData;
			end else begin
				tailData <= PushData;
			end
		end
	end

	noPushWhenFull: assert property (@(posedge Clock) disable iff (rst)
		Push |-> used != QueueFreeWidth'(QueueDepth))
		else $error("push into a full encryption queue");

endmodule

`default_nettype wire

//--- verilog/PathBufferRam.sv
// PathBufferRam
// Path buffer memory, read-write main port and read-only stash port

`timescale 1ns/10ps
`default_nettype none

module PathBufferRam import PathBufferPkg::*; #(
	parameter int DataWidth = DefaultDataWidth,
	parameter int PathBursts = DefaultPathBursts
) (
	input  wire                                   Clock,
	input  wire                                   PortEnable,
	input  wire                                   PortWrite,
	input  wire  [BufferAddrWidth(PathBursts)-1:0] PortAddr,
	input  wire  [DataWidth-1:0]                  PortDataIn,
	input  wire                                   StashReadEnable,
	input  wire  [BlockCountWidth(PathBursts)-1:0] StashReadAddr,
	output logic [DataWidth-1:0]                  PortDataOut,
	output logic [DataWidth-1:0]                  StashReadData
);

	localparam int AddrWidth = BufferAddrWidth(PathBursts);
	localparam int Depth = 2 * PathBursts + 2;

	logic [DataWidth-1:0] mem [0:Depth-1];

	always_ff @(posedge Clock) begin
		if (PortEnable) begin
			if (PortWrite) begin
				mem[PortAddr] <= PortDataIn;
			end else begin
				PortDataOut <= mem[PortAddr]; // Registered drain read
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (StashReadEnable) begin
			StashReadData <= mem[AddrWidth'(StashReadAddr)]; // Lower half only
		end
	end

	addrInRange: assert property (@(posedge Clock)
		PortEnable |-> PortAddr < Depth)
		else $error("buffer address out of range");

endmodule

`default_nettype wire

//--- pathPortArbiter/PathPortArbiter.sv
// PathPortArbiter
// Picks source, direction and address of the buffer main port per access phase
// and issues the drain pushes into the encryption queue

`timescale 1ns/10ps
`default_nettype none

module PathPortArbiter import PathBufferPkg::*; #(
	parameter int DataWidth = DefaultDataWidth,
	parameter int PathBursts = DefaultPathBursts
) (
	input  wire                                   Clock,
	input  wire                                   rst,
	input  wire                                   RWAccess,
	input  wire                                   CSPathRead,
	input  wire                                   CSPathWriteback,
	input  wire                                   DecTransfer,
	input  wire                                   StashTransfer,
	input  wire  [DataWidth-1:0]                  DecData,
	input  wire  [DataWidth-1:0]                  StashData,
	input  wire  [QueueFreeWidth-1:0]             QueueFree,
	output logic                                  PortEnable,
	output logic                                  PortWrite,
	output logic [BufferAddrWidth(PathBursts)-1:0] PortAddr,
	output logic [DataWidth-1:0]                  PortDataIn,
	output logic                                  QueuePush,
	output logic                                  PathTransition,
	output logic [BlockCountWidth(PathBursts)-1:0] BlockCount
);

	localparam int AddrWidth = BufferAddrWidth(PathBursts);

	logic fillStep; // Writeback is filling the upper half from the stash
	logic drainReady;

	// Room left in the queue after the drain already in flight lands
	assign drainReady = QueueFree > QueueFreeWidth'(QueuePush);

	always_comb begin
		PortEnable = 1'b0;
		PortWrite = 1'b0;
		if (RWAccess) begin
			if (CSPathRead) begin
				PortEnable = DecTransfer;
				PortWrite = 1'b1;
			end else if (CSPathWriteback) begin
				PortEnable = fillStep ? StashTransfer : drainReady;
				PortWrite = fillStep;
			end
		end
	end

	assign PortAddr = CSPathRead ? AddrWidth'(BlockCount)
		: AddrWidth'(BlockCount) + AddrWidth'(PathBursts); // Upper half during writeback
	assign PortDataIn = CSPathRead ? DecData : StashData;

	PathBlockCounter #(
		.PathBursts(PathBursts)
	) blockCounter (
		.Clock(Clock),
		.rst(rst),
		.Advance(PortEnable),
		.Count(BlockCount),
		.Done(PathTransition)
	);

	always_ff @(posedge Clock) begin
		if (rst) begin
			fillStep <= 1'b1;
			QueuePush <= 1'b0;
		end else begin
			QueuePush <= PortEnable && !PortWrite; // Read data arrives next cycle
			if (CSPathWriteback && PathTransition) begin
				fillStep <= !fillStep; // Switch between fill and drain
			end
		end
	end

	// Drain pacing must never overrun the queue
	pushHasRoom: assert property (@(posedge Clock) disable iff (rst)
		QueuePush |-> QueueFree != '0)
		else $error("queue push with no free entry");

	writeInAccess: assert property (@(posedge Clock) disable iff (rst)
		(PortEnable && PortWrite) |-> (RWAccess && (CSPathRead || CSPathWriteback)))
		else $error("buffer write outside a read-write access");

endmodule

`default_nettype wire

//--- pathPortArbiter/PathBlockCounter.sv
// PathBlockCounter
// Counts block transfers along one path half and pulses on the last one

`timescale 1ns/10ps
`default_nettype none

module PathBlockCounter import PathBufferPkg::*; #(
	parameter int PathBursts = DefaultPathBursts
) (
	input  wire                                  Clock,
	input  wire                                  rst,
	input  wire                                  Advance,
	output logic [BlockCountWidth(PathBursts)-1:0] Count,
	output logic                                 Done
);

	localparam int CountWidth = BlockCountWidth(PathBursts);
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(PathBursts - 1);

	assign Done = Advance && (Count == LastCount); // Last block of the half

	always_ff @(posedge Clock) begin
		if (rst) begin
			Count <= '0;
		end else if (Advance) begin
			if (Done) begin
				Count <= '0; // Wrap for the next half
			end else begin
				Count <= Count + 1'b1;
			end
		end
	end

	// Wrap must happen before the index leaves the half
	countInRange: assert property (@(posedge Clock) disable iff (rst)
		Count < PathBursts)
		else $error("block count reached PathBursts");

endmodule

`default_nettype wire

//--- common/PathBufferPkg.sv
// PathBufferPkg
// Default sizes and width helpers shared by the path buffer port

`default_nettype none

package PathBufferPkg;

	localparam int DefaultDataWidth = 32; // One burst of payload
	localparam int DefaultPathBursts = 6; // Bursts per path half

	localparam int QueueDepth = 2; // Entries in the encryption queue
	localparam int QueueFreeWidth = $clog2(QueueDepth + 1); // Holds 0..QueueDepth

	// Two path halves plus two spare entries
	function automatic int BufferAddrWidth(input int pathBursts);
		return $clog2(2 * pathBursts + 2);
	endfunction

	// Index of a block within one path half
	function automatic int BlockCountWidth(input int pathBursts);
		if (pathBursts <= 1) begin
			return 1;
		end
		return $clog2(pathBursts);
	endfunction

endpackage

`default_nettype wire
